/* csr_macros.svh */
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

`define CSR_XLEN    32
`define CSR_ADDR_W  12
`define CSR_CAUSE_W 5

// machine level
`define CSR_ADDR_MSTATUS  12'h300
`define CSR_ADDR_MEDELEG  12'h302
`define CSR_ADDR_MIE      12'h304
`define CSR_ADDR_MTVEC    12'h305
`define CSR_ADDR_MSCRATCH 12'h340
`define CSR_ADDR_MEPC     12'h341
`define CSR_ADDR_MCAUSE   12'h342
`define CSR_ADDR_MTVAL    12'h343
// supervisor level
`define CSR_ADDR_SSTATUS  12'h100
`define CSR_ADDR_SIE      12'h104
`define CSR_ADDR_STVEC    12'h105
`define CSR_ADDR_SSCRATCH 12'h140
`define CSR_ADDR_SEPC     12'h141
`define CSR_ADDR_SCAUSE   12'h142
`define CSR_ADDR_STVAL    12'h143
`define CSR_ADDR_SATP     12'h180

`define CSR_MASK_MSTATUS  32'h0004_19AA // sie mie spie mpie spp mpp sum
`define CSR_MASK_MEDELEG  32'h0000_B3FF // ecall from M never delegated
`define CSR_MASK_MIE      32'h0000_0AAA
`define CSR_MASK_MTVEC    32'hFFFF_FFFC // direct mode only
`define CSR_MASK_MSCRATCH 32'hFFFF_FFFF
`define CSR_MASK_MEPC     32'hFFFF_FFFC
`define CSR_MASK_MCAUSE   32'h0000_001F
`define CSR_MASK_MTVAL    32'hFFFF_FFFF
`define CSR_MASK_SSTATUS  32'h0004_0122 // sie spie spp sum
`define CSR_MASK_SIE      32'h0000_0222
`define CSR_MASK_STVEC    32'hFFFF_FFFC
`define CSR_MASK_SSCRATCH 32'hFFFF_FFFF
`define CSR_MASK_SEPC     32'hFFFF_FFFC
`define CSR_MASK_SCAUSE   32'h0000_001F
`define CSR_MASK_STVAL    32'hFFFF_FFFF
`define CSR_MASK_SATP     32'hFFFF_FFFF

`define CSR_MSTATUS_SIE    1
`define CSR_MSTATUS_MIE    3
`define CSR_MSTATUS_SPIE   5
`define CSR_MSTATUS_MPIE   7
`define CSR_MSTATUS_SPP    8
`define CSR_MSTATUS_MPP_LO 11
`define CSR_MSTATUS_MPP_HI 12
`define CSR_MSTATUS_SUM    18

`define CSR_CAUSE_INST_MISALIGNED  5'd0
`define CSR_CAUSE_INST_FAULT       5'd1
`define CSR_CAUSE_ILLEGAL_INST     5'd2
`define CSR_CAUSE_BREAKPOINT       5'd3
`define CSR_CAUSE_LOAD_MISALIGNED  5'd4
`define CSR_CAUSE_LOAD_FAULT       5'd5
`define CSR_CAUSE_STORE_MISALIGNED 5'd6
`define CSR_CAUSE_STORE_FAULT      5'd7
`define CSR_CAUSE_ECALL_U          5'd8
`define CSR_CAUSE_ECALL_S          5'd9
`define CSR_CAUSE_ECALL_M          5'd11
`define CSR_CAUSE_INST_PAGE_FAULT  5'd12
`define CSR_CAUSE_LOAD_PAGE_FAULT  5'd13
`define CSR_CAUSE_STORE_PAGE_FAULT 5'd15
`define CSR_CAUSE_NONE             5'd31 // no trap this cycle

`endif

/* csr_pkg.sv */
`default_nettype none

`include "csr_macros.svh"

package csr_pkg;

    typedef logic [`CSR_XLEN-1:0]    xlen_t;
    typedef logic [`CSR_ADDR_W-1:0]  csr_addr_t;
    typedef logic [`CSR_CAUSE_W-1:0] cause_t;

    // spec privilege encoding with 2 reserved
    typedef enum logic [1:0] {
        priv_user    = 2'd0,
        priv_super   = 2'd1,
        priv_machine = 2'd3
    } priv_e;

endpackage

`default_nettype wire

/* csr_trap_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_macros.svh"

module csr_trap_ctrl (
    input  csr_pkg::cause_t trap_cause,
    input  csr_pkg::xlen_t  trap_pc,
    input  csr_pkg::xlen_t  trap_inst,
    input  csr_pkg::xlen_t  fault_va,
    input  logic            ecall,
    input  logic            mret,
    input  logic            sret,
    input  csr_pkg::priv_e  cur_priv,
    input  csr_pkg::xlen_t  cur_status,
    input  csr_pkg::xlen_t  medeleg,
    output logic            take_trap,
    output logic            trap_to_super,
    output logic            do_mret,
    output logic            do_sret,
    output csr_pkg::cause_t eff_cause,
    output csr_pkg::priv_e  next_priv,
    output csr_pkg::xlen_t  next_status,
    output csr_pkg::xlen_t  tval_value
);
    import csr_pkg::*;

    // ecall code depends on who made the call
    always_comb begin
        eff_cause = trap_cause;
        if (ecall) begin
            case (cur_priv)
                priv_user:  eff_cause = `CSR_CAUSE_ECALL_U;
                priv_super: eff_cause = `CSR_CAUSE_ECALL_S;
                default:    eff_cause = `CSR_CAUSE_ECALL_M;
            endcase
        end
    end

    assign take_trap     = (eff_cause != `CSR_CAUSE_NONE);
    assign trap_to_super = take_trap && medeleg[eff_cause] && (cur_priv != priv_machine);
    assign do_mret       = mret && !take_trap;          // trap beats mret
    assign do_sret       = sret && !take_trap && !mret; // mret beats sret

    always_comb begin
        next_status = cur_status;
        next_priv   = cur_priv;
        if (trap_to_super) begin
            next_status[`CSR_MSTATUS_SPIE] = cur_status[`CSR_MSTATUS_SIE];
            next_status[`CSR_MSTATUS_SPP]  = cur_priv[0]; // only U or S get here
            next_status[`CSR_MSTATUS_SIE]  = 1'b0;
            next_priv                      = priv_super;
        end else if (take_trap) begin
            next_status[`CSR_MSTATUS_MPIE] = cur_status[`CSR_MSTATUS_MIE];
            next_status[`CSR_MSTATUS_MPP_HI:`CSR_MSTATUS_MPP_LO] = cur_priv;
            next_status[`CSR_MSTATUS_MIE]  = 1'b0;
            next_priv                      = priv_machine;
        end else if (do_mret) begin
            case (cur_status[`CSR_MSTATUS_MPP_HI:`CSR_MSTATUS_MPP_LO])
                2'b00:   next_priv = priv_user;
                2'b01:   next_priv = priv_super;
                default: next_priv = priv_machine; // reserved 2 goes to M
            endcase
            next_status[`CSR_MSTATUS_MIE]  = cur_status[`CSR_MSTATUS_MPIE];
            next_status[`CSR_MSTATUS_MPIE] = 1'b1;
            next_status[`CSR_MSTATUS_MPP_HI:`CSR_MSTATUS_MPP_LO] = 2'b00;
        end else if (do_sret) begin
            next_priv = cur_status[`CSR_MSTATUS_SPP] ? priv_super : priv_user;
            next_status[`CSR_MSTATUS_SIE]  = cur_status[`CSR_MSTATUS_SPIE];
            next_status[`CSR_MSTATUS_SPIE] = 1'b1;
            next_status[`CSR_MSTATUS_SPP]  = 1'b0;
        end
    end

    // tval payload by cause
    always_comb begin
        case (eff_cause)
            `CSR_CAUSE_INST_MISALIGNED,
            `CSR_CAUSE_INST_FAULT,
            `CSR_CAUSE_BREAKPOINT,
            `CSR_CAUSE_INST_PAGE_FAULT:  tval_value = trap_pc;
            `CSR_CAUSE_ILLEGAL_INST:     tval_value = trap_inst;
            `CSR_CAUSE_LOAD_MISALIGNED,
            `CSR_CAUSE_LOAD_FAULT,
            `CSR_CAUSE_STORE_MISALIGNED,
            `CSR_CAUSE_STORE_FAULT,
            `CSR_CAUSE_LOAD_PAGE_FAULT,
            `CSR_CAUSE_STORE_PAGE_FAULT: tval_value = fault_va; // data address
            default:                     tval_value = '0;       // ecalls and the rest
        endcase
    end

endmodule

`default_nettype wire

/* csr_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_macros.svh"

module csr_regs (
    input  logic               clk,
    input  logic               rst,
    input  logic               wen,
    input  csr_pkg::csr_addr_t waddr,
    input  csr_pkg::xlen_t     wdata,
    input  logic               take_trap,
    input  logic               trap_to_super,
    input  logic               do_mret,
    input  logic               do_sret,
    input  csr_pkg::cause_t    eff_cause,
    input  csr_pkg::xlen_t     trap_pc,
    input  csr_pkg::xlen_t     tval_value,
    input  csr_pkg::xlen_t     next_status,
    input  csr_pkg::priv_e     next_priv,
    output csr_pkg::priv_e     priv,
    output csr_pkg::xlen_t     mstatus,
    output csr_pkg::xlen_t     medeleg,
    output csr_pkg::xlen_t     mie,
    output csr_pkg::xlen_t     mtvec,
    output csr_pkg::xlen_t     mscratch,
    output csr_pkg::xlen_t     mepc,
    output csr_pkg::xlen_t     mcause,
    output csr_pkg::xlen_t     mtval,
    output csr_pkg::xlen_t     stvec,
    output csr_pkg::xlen_t     sscratch,
    output csr_pkg::xlen_t     sepc,
    output csr_pkg::xlen_t     scause,
    output csr_pkg::xlen_t     stval,
    output csr_pkg::xlen_t     satp
);
    import csr_pkg::*;

    xlen_t cause_word;

    // keep the bits outside the mask and take the rest from the write
    function automatic xlen_t merge(input xlen_t old_val, input xlen_t new_val,
                                    input xlen_t mask);
        return (old_val & ~mask) | (new_val & mask);
    endfunction

    assign cause_word = {{(`CSR_XLEN - `CSR_CAUSE_W){1'b0}}, eff_cause};

    always_ff @(posedge clk) begin
        if (rst) begin
            priv     <= priv_machine;
            mstatus  <= '0;
            medeleg  <= '0;
            mie      <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
            stvec    <= '0;
            sscratch <= '0;
            sepc     <= '0;
            scause   <= '0;
            stval    <= '0;
            satp     <= '0;
        end else begin
            if (wen) begin
                case (waddr)
                    `CSR_ADDR_MSTATUS:  mstatus  <= merge(mstatus, wdata, `CSR_MASK_MSTATUS);
                    `CSR_ADDR_SSTATUS:  mstatus  <= merge(mstatus, wdata, `CSR_MASK_SSTATUS);
                    `CSR_ADDR_MEDELEG:  medeleg  <= merge(medeleg, wdata, `CSR_MASK_MEDELEG);
                    `CSR_ADDR_MIE:      mie      <= merge(mie, wdata, `CSR_MASK_MIE);
                    `CSR_ADDR_SIE:      mie      <= merge(mie, wdata, `CSR_MASK_SIE);
                    `CSR_ADDR_MTVEC:    mtvec    <= merge(mtvec, wdata, `CSR_MASK_MTVEC);
                    `CSR_ADDR_MSCRATCH: mscratch <= merge(mscratch, wdata, `CSR_MASK_MSCRATCH);
                    `CSR_ADDR_MEPC:     mepc     <= merge(mepc, wdata, `CSR_MASK_MEPC);
                    `CSR_ADDR_MCAUSE:   mcause   <= merge(mcause, wdata, `CSR_MASK_MCAUSE);
                    `CSR_ADDR_MTVAL:    mtval    <= merge(mtval, wdata, `CSR_MASK_MTVAL);
                    `CSR_ADDR_STVEC:    stvec    <= merge(stvec, wdata, `CSR_MASK_STVEC);
                    `CSR_ADDR_SSCRATCH: sscratch <= merge(sscratch, wdata, `CSR_MASK_SSCRATCH);
                    `CSR_ADDR_SEPC:     sepc     <= merge(sepc, wdata, `CSR_MASK_SEPC);
                    `CSR_ADDR_SCAUSE:   scause   <= merge(scause, wdata, `CSR_MASK_SCAUSE);
                    `CSR_ADDR_STVAL:    stval    <= merge(stval, wdata, `CSR_MASK_STVAL);
                    `CSR_ADDR_SATP:     satp     <= merge(satp, wdata, `CSR_MASK_SATP);
                    default: ; // write to an unknown address is dropped
                endcase
            end

            // later assignments win over the software write above
            if (take_trap || do_mret || do_sret) begin
                mstatus <= next_status;
                priv    <= next_priv;
            end
            if (take_trap) begin
                if (trap_to_super) begin
                    scause <= cause_word;
                    sepc   <= trap_pc & `CSR_MASK_SEPC;
                    stval  <= tval_value;
                end else begin
                    mcause <= cause_word;
                    mepc   <= trap_pc & `CSR_MASK_MEPC;
                    mtval  <= tval_value;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* csr_read_mux.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_macros.svh"

module csr_read_mux (
    input  logic               ren,
    input  csr_pkg::csr_addr_t raddr,
    input  csr_pkg::xlen_t     mstatus,
    input  csr_pkg::xlen_t     medeleg,
    input  csr_pkg::xlen_t     mie,
    input  csr_pkg::xlen_t     mtvec,
    input  csr_pkg::xlen_t     mscratch,
    input  csr_pkg::xlen_t     mepc,
    input  csr_pkg::xlen_t     mcause,
    input  csr_pkg::xlen_t     mtval,
    input  csr_pkg::xlen_t     stvec,
    input  csr_pkg::xlen_t     sscratch,
    input  csr_pkg::xlen_t     sepc,
    input  csr_pkg::xlen_t     scause,
    input  csr_pkg::xlen_t     stval,
    input  csr_pkg::xlen_t     satp,
    output csr_pkg::xlen_t     rdata
);
    import csr_pkg::*;

    xlen_t sel;

    always_comb begin
        case (raddr)
            `CSR_ADDR_MSTATUS:  sel = mstatus & `CSR_MASK_MSTATUS;
            `CSR_ADDR_SSTATUS:  sel = mstatus & `CSR_MASK_SSTATUS; // alias view
            `CSR_ADDR_MEDELEG:  sel = medeleg & `CSR_MASK_MEDELEG;
            `CSR_ADDR_MIE:      sel = mie & `CSR_MASK_MIE;
            `CSR_ADDR_SIE:      sel = mie & `CSR_MASK_SIE;
            `CSR_ADDR_MTVEC:    sel = mtvec & `CSR_MASK_MTVEC;
            `CSR_ADDR_MSCRATCH: sel = mscratch & `CSR_MASK_MSCRATCH;
            `CSR_ADDR_MEPC:     sel = mepc & `CSR_MASK_MEPC;
            `CSR_ADDR_MCAUSE:   sel = mcause & `CSR_MASK_MCAUSE;
            `CSR_ADDR_MTVAL:    sel = mtval & `CSR_MASK_MTVAL;
            `CSR_ADDR_STVEC:    sel = stvec & `CSR_MASK_STVEC;
            `CSR_ADDR_SSCRATCH: sel = sscratch & `CSR_MASK_SSCRATCH;
            `CSR_ADDR_SEPC:     sel = sepc & `CSR_MASK_SEPC;
            `CSR_ADDR_SCAUSE:   sel = scause & `CSR_MASK_SCAUSE;
            `CSR_ADDR_STVAL:    sel = stval & `CSR_MASK_STVAL;
            `CSR_ADDR_SATP:     sel = satp & `CSR_MASK_SATP;
            default:            sel = '0; // dropped or unknown
        endcase
    end

    assign rdata = ren ? sel : '0;

endmodule

`default_nettype wire

/* csr_redirect.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_macros.svh"

module csr_redirect (
    input  logic               clk,
    input  logic               rst,
    input  logic               take_trap,
    input  logic               trap_to_super,
    input  logic               do_mret,
    input  logic               do_sret,
    input  csr_pkg::csr_addr_t ex_addr,
    input  csr_pkg::csr_addr_t mem_addr,
    input  csr_pkg::xlen_t     ex_data,
    input  csr_pkg::xlen_t     mem_data,
    input  csr_pkg::xlen_t     mepc,
    input  csr_pkg::xlen_t     sepc,
    input  csr_pkg::xlen_t     mtvec,
    input  csr_pkg::xlen_t     stvec,
    output logic               redirect_valid,
    output csr_pkg::xlen_t     redirect_pc
);
    import csr_pkg::*;

    logic      redirect_req;
    csr_addr_t tgt_addr;
    xlen_t     tgt_val;
    xlen_t     fwd_val;

    assign redirect_req = take_trap || do_mret || do_sret;

    // which register holds the new pc
    always_comb begin
        if (do_mret) begin
            tgt_addr = `CSR_ADDR_MEPC;
            tgt_val  = mepc;
        end else if (do_sret) begin
            tgt_addr = `CSR_ADDR_SEPC;
            tgt_val  = sepc;
        end else if (trap_to_super) begin
            tgt_addr = `CSR_ADDR_STVEC;
            tgt_val  = stvec;
        end else begin
            tgt_addr = `CSR_ADDR_MTVEC;
            tgt_val  = mtvec;
        end
    end

    // younger write in EX wins over MEM
    assign fwd_val = (ex_addr == tgt_addr)  ? ex_data  :
                     (mem_addr == tgt_addr) ? mem_data : tgt_val;

    always_ff @(posedge clk) begin
        if (rst) begin
            redirect_valid <= 1'b0;
            redirect_pc    <= '0;
        end else begin
            redirect_valid <= redirect_req;                // one pulse per request
            redirect_pc    <= redirect_req ? fwd_val : '0;
        end
    end

endmodule

`default_nettype wire

/* csr_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_macros.svh"

module csr_file (
    input  logic               clk,
    input  logic               rst,
    input  logic               wen,
    input  csr_pkg::csr_addr_t waddr,
    input  csr_pkg::xlen_t     wdata,
    input  logic               ren,
    input  csr_pkg::csr_addr_t raddr,
    output csr_pkg::xlen_t     rdata,
    output csr_pkg::xlen_t     status,
    input  csr_pkg::xlen_t     trap_pc,
    input  csr_pkg::cause_t    trap_cause,
    input  csr_pkg::xlen_t     trap_inst,
    input  csr_pkg::xlen_t     fault_va,
    input  logic               ecall,
    input  logic               mret,
    input  logic               sret,
    output logic               redirect_valid,
    output csr_pkg::xlen_t     redirect_pc,
    input  csr_pkg::csr_addr_t ex_addr,
    input  csr_pkg::xlen_t     ex_data,
    input  csr_pkg::csr_addr_t mem_addr,
    input  csr_pkg::xlen_t     mem_data,
    output csr_pkg::priv_e     priv,
    output csr_pkg::xlen_t     satp,
    output logic               sum
);
    import csr_pkg::*;

    logic   take_trap;
    logic   trap_to_super;
    logic   do_mret;
    logic   do_sret;
    cause_t eff_cause;
    priv_e  next_priv;
    xlen_t  next_status;
    xlen_t  tval_value;

    xlen_t mstatus, medeleg, mie, mtvec, mscratch, mepc, mcause, mtval;
    xlen_t stvec, sscratch, sepc, scause, stval;

    csr_trap_ctrl trap_ctrl_i (
        .trap_cause   (trap_cause),
        .trap_pc      (trap_pc),
        .trap_inst    (trap_inst),
        .fault_va     (fault_va),
        .ecall        (ecall),
        .mret         (mret),
        .sret         (sret),
        .cur_priv     (priv),
        .cur_status   (mstatus),
        .medeleg      (medeleg),
        .take_trap    (take_trap),
        .trap_to_super(trap_to_super),
        .do_mret      (do_mret),
        .do_sret      (do_sret),
        .eff_cause    (eff_cause),
        .next_priv    (next_priv),
        .next_status  (next_status),
        .tval_value   (tval_value)
    );

    csr_regs regs_i (
        .clk, .rst, .wen, .waddr, .wdata,
        .take_trap, .trap_to_super, .do_mret, .do_sret,
        .eff_cause, .trap_pc, .tval_value, .next_status, .next_priv,
        .priv, .mstatus, .medeleg, .mie, .mtvec, .mscratch, .mepc, .mcause,
        .mtval, .stvec, .sscratch, .sepc, .scause, .stval, .satp
    );

    csr_read_mux read_mux_i (
        .ren, .raddr,
        .mstatus, .medeleg, .mie, .mtvec, .mscratch, .mepc, .mcause,
        .mtval, .stvec, .sscratch, .sepc, .scause, .stval, .satp,
        .rdata
    );

    csr_redirect redirect_i (
        .clk, .rst, .take_trap, .trap_to_super, .do_mret, .do_sret,
        .ex_addr, .mem_addr, .ex_data, .mem_data,
        .mepc, .sepc, .mtvec, .stvec,
        .redirect_valid, .redirect_pc
    );

    assign status = mstatus;
    assign sum    = mstatus[`CSR_MSTATUS_SUM]; // for the MMU

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter real period_ns = 100.0
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(period_ns / 2.0) clk = ~clk; // free running at 50% duty

endmodule

`default_nettype wire

/* tb_csr_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_macros.svh"

module tb_csr_file;
    import csr_pkg::*;

    localparam int reset_cycles = 16;
    localparam int n_entries    = 17;
    localparam int write_cycles = 300;
    localparam int mixed_cycles = 1500;
    localparam int cycle_limit  = reset_cycles + n_entries + write_cycles + mixed_cycles + 200;
    localparam int slot_mstatus = 0;
    localparam int slot_medeleg = 1;
    localparam int slot_mtvec   = 3;
    localparam int slot_mepc    = 5;
    localparam int slot_mcause  = 6;
    localparam int slot_mtval   = 7;
    localparam int slot_stvec   = 8;
    localparam int slot_sepc    = 10;
    localparam int slot_scause  = 11;
    localparam int slot_stval   = 12;
    localparam int slot_satp    = 13;
    localparam int vec_entry [4] = '{3, 5, 10, 12}; // mtvec, mepc, stvec, sepc

    logic      clk;
    logic      rst;
    logic      wen;
    logic      ren;
    logic      ecall;
    logic      mret;
    logic      sret;
    logic      redirect_valid;
    logic      sum;
    csr_addr_t waddr;
    csr_addr_t raddr;
    csr_addr_t ex_addr;
    csr_addr_t mem_addr;
    xlen_t     wdata, trap_pc, trap_inst, fault_va, ex_data, mem_data;
    xlen_t     rdata, status, redirect_pc, satp;
    cause_t    trap_cause;
    priv_e     priv;

    // reference model
    csr_addr_t   addr_tab [n_entries];
    xlen_t       mask_tab [n_entries];
    int          slot_tab [n_entries];
    xlen_t       st [15];     // slot 14 backs the unknown address
    logic [1:0]  m_priv;
    logic        exp_valid;
    xlen_t       exp_pc;
    logic [31:0] lfsr;
    int          rd_entry;
    int          wr_entry;
    int          errors;
    int          checks;
    int          cycle_count = 0;

    tb_clock_gen clock_gen_i (.clk(clk));

    csr_file csr_file_i (
        .clk, .rst, .wen, .waddr, .wdata, .ren, .raddr, .rdata, .status,
        .trap_pc, .trap_cause, .trap_inst, .fault_va, .ecall, .mret, .sret,
        .redirect_valid, .redirect_pc, .ex_addr, .ex_data, .mem_addr, .mem_data,
        .priv, .satp, .sum
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic int random_entry();
        return int'(take_bits(5)) % n_entries;
    endfunction

    task automatic set_entry(input int i, input csr_addr_t a, input xlen_t m, input int s);
        addr_tab[i] = a;
        mask_tab[i] = m;
        slot_tab[i] = s;
    endtask

    task automatic check_value(input string name, input xlen_t got, input xlen_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_outputs();
        xlen_t exp_rd;
        exp_rd = ren ? (st[slot_tab[rd_entry]] & mask_tab[rd_entry]) : '0;
        check_value("rdata", rdata, exp_rd);
        check_value("status", status, st[slot_mstatus]);
        check_value("satp", satp, st[slot_satp]);
        check_value("sum", {31'b0, sum}, {31'b0, st[slot_mstatus][`CSR_MSTATUS_SUM]});
        check_value("priv", {30'b0, priv}, {30'b0, m_priv});
        check_value("redirect_valid", {31'b0, redirect_valid}, {31'b0, exp_valid});
        check_value("redirect_pc", redirect_pc, exp_pc);
    endtask

    // next state from the inputs driven this cycle
    task automatic apply_model();
        xlen_t      old_st;
        xlen_t      nstat;
        xlen_t      tval;
        cause_t     eff;
        logic       trap;
        logic       deleg;
        logic       do_m;
        logic       do_s;
        logic [1:0] new_priv;
        int         tgt;
        csr_addr_t  tgt_addr;
        old_st   = st[slot_mstatus];
        nstat    = old_st;
        new_priv = m_priv;
        eff      = trap_cause;
        if (ecall)
            eff = (m_priv == 2'd0) ? `CSR_CAUSE_ECALL_U :
                  (m_priv == 2'd1) ? `CSR_CAUSE_ECALL_S : `CSR_CAUSE_ECALL_M;
        trap  = (eff != `CSR_CAUSE_NONE);
        deleg = trap && st[slot_medeleg][eff] && (m_priv != 2'd3);
        do_m  = mret && !trap;
        do_s  = sret && !trap && !mret;
        case (eff)
            5'd0, 5'd1, 5'd3, 5'd12:              tval = trap_pc;
            5'd2:                                 tval = trap_inst;
            5'd4, 5'd5, 5'd6, 5'd7, 5'd13, 5'd15: tval = fault_va;
            default:                              tval = '0;
        endcase

        tgt      = do_m ? slot_mepc : do_s ? slot_sepc : deleg ? slot_stvec : slot_mtvec;
        tgt_addr = do_m ? `CSR_ADDR_MEPC : do_s ? `CSR_ADDR_SEPC :
                   deleg ? `CSR_ADDR_STVEC : `CSR_ADDR_MTVEC;
        exp_valid = trap || do_m || do_s;
        exp_pc    = !exp_valid ? '0 : (ex_addr == tgt_addr) ? ex_data :
                    (mem_addr == tgt_addr) ? mem_data : st[tgt];

        if (deleg) begin
            nstat[`CSR_MSTATUS_SPIE] = old_st[`CSR_MSTATUS_SIE];
            nstat[`CSR_MSTATUS_SPP]  = m_priv[0];
            nstat[`CSR_MSTATUS_SIE]  = 1'b0;
            new_priv = 2'd1;
        end else if (trap) begin
            nstat[`CSR_MSTATUS_MPIE] = old_st[`CSR_MSTATUS_MIE];
            nstat[`CSR_MSTATUS_MPP_HI:`CSR_MSTATUS_MPP_LO] = m_priv;
            nstat[`CSR_MSTATUS_MIE]  = 1'b0;
            new_priv = 2'd3;
        end else if (do_m) begin
            new_priv = old_st[`CSR_MSTATUS_MPP_HI:`CSR_MSTATUS_MPP_LO];
            if (new_priv == 2'd2)
                new_priv = 2'd3; // reserved MPP returns to M
            nstat[`CSR_MSTATUS_MIE]  = old_st[`CSR_MSTATUS_MPIE];
            nstat[`CSR_MSTATUS_MPIE] = 1'b1;
            nstat[`CSR_MSTATUS_MPP_HI:`CSR_MSTATUS_MPP_LO] = 2'b00;
        end else if (do_s) begin
            new_priv = old_st[`CSR_MSTATUS_SPP] ? 2'd1 : 2'd0;
            nstat[`CSR_MSTATUS_SIE]  = old_st[`CSR_MSTATUS_SPIE];
            nstat[`CSR_MSTATUS_SPIE] = 1'b1;
            nstat[`CSR_MSTATUS_SPP]  = 1'b0;
        end

        if (wen)
            st[slot_tab[wr_entry]] = (st[slot_tab[wr_entry]] & ~mask_tab[wr_entry]) |
                                     (wdata & mask_tab[wr_entry]);
        if (exp_valid) begin // trap or return overrides the write
            st[slot_mstatus] = nstat;
            m_priv           = new_priv;
        end
        if (trap && deleg) begin
            st[slot_scause] = {27'b0, eff};
            st[slot_sepc]   = trap_pc & `CSR_MASK_SEPC;
            st[slot_stval]  = tval;
        end else if (trap) begin
            st[slot_mcause] = {27'b0, eff};
            st[slot_mepc]   = trap_pc & `CSR_MASK_MEPC;
            st[slot_mtval]  = tval;
        end
    endtask

    // mode 0 reads entry idx, mode 1 writes and reads, mode 2 mixes in traps and returns
    task automatic drive_inputs(input int mode, input int idx);
        logic [2:0] ev;
        logic [1:0] sel;
        int         prev_w;
        prev_w     = wr_entry;
        wen        = 1'b0;
        ren        = 1'b1;
        ecall      = 1'b0;
        mret       = 1'b0;
        sret       = 1'b0;
        trap_cause = `CSR_CAUSE_NONE;
        wdata      = take_bits(32);
        trap_pc    = take_bits(32);
        trap_inst  = take_bits(32);
        fault_va   = take_bits(32);
        ex_data    = take_bits(32);
        mem_data   = take_bits(32);
        ex_addr    = addr_tab[random_entry()];
        mem_addr   = addr_tab[random_entry()];
        if (mode == 0) begin
            rd_entry = idx;
        end else if (mode == 1) begin
            wen      = 1'b1;
            wr_entry = random_entry();
            rd_entry = take_bits(1) ? prev_w : random_entry(); // often read back
            ren      = (take_bits(3) != 0);
        end else begin
            wen      = 1'(take_bits(1));
            sel      = 2'(take_bits(2));
            wr_entry = (sel == 0) ? 0 : (sel == 1) ? 1 : (sel == 2) ? 15 : random_entry();
            ev       = 3'(take_bits(3));
            if (ev <= 1) begin
                trap_cause = cause_t'(take_bits(4));
                mret       = 1'(take_bits(1));
                sret       = 1'(take_bits(1));
            end
            ecall = (ev == 2);
            if (ev == 3 || ev == 5)
                mret = 1'b1;
            if (ev == 4 || ev == 5)
                sret = 1'b1;
            if ((mret || sret) && take_bits(2) == 0) begin
                wen      = 1'b1;
                wr_entry = 0; // mstatus write racing the return
            end
            if (take_bits(1))
                ex_addr = addr_tab[vec_entry[take_bits(2)]];
            if (take_bits(1))
                mem_addr = addr_tab[vec_entry[take_bits(2)]];
            rd_entry = random_entry();
        end
        waddr = addr_tab[wr_entry];
        raddr = addr_tab[rd_entry];
        apply_model();
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        lfsr       = 32'h872;
        errors     = 0;
        checks     = 0;
        rst        = 1'b1;
        wen        = 1'b0;
        ren        = 1'b0;
        ecall      = 1'b0;
        mret       = 1'b0;
        sret       = 1'b0;
        waddr      = '0;
        raddr      = '0;
        wdata      = '0;
        trap_pc    = '0;
        trap_inst  = '0;
        fault_va   = '0;
        trap_cause = `CSR_CAUSE_NONE;
        ex_addr    = '0;
        ex_data    = '0;
        mem_addr   = '0;
        mem_data   = '0;
        for (int i = 0; i < 15; i++)
            st[i] = '0;
        m_priv    = 2'd3;
        exp_valid = 1'b0;
        exp_pc    = '0;
        rd_entry  = 16;
        wr_entry  = 16;
        set_entry(0, `CSR_ADDR_MSTATUS, `CSR_MASK_MSTATUS, 0);
        set_entry(1, `CSR_ADDR_MEDELEG, `CSR_MASK_MEDELEG, 1);
        set_entry(2, `CSR_ADDR_MIE, `CSR_MASK_MIE, 2);
        set_entry(3, `CSR_ADDR_MTVEC, `CSR_MASK_MTVEC, 3);
        set_entry(4, `CSR_ADDR_MSCRATCH, `CSR_MASK_MSCRATCH, 4);
        set_entry(5, `CSR_ADDR_MEPC, `CSR_MASK_MEPC, 5);
        set_entry(6, `CSR_ADDR_MCAUSE, `CSR_MASK_MCAUSE, 6);
        set_entry(7, `CSR_ADDR_MTVAL, `CSR_MASK_MTVAL, 7);
        set_entry(8, `CSR_ADDR_SSTATUS, `CSR_MASK_SSTATUS, 0);  // alias of mstatus
        set_entry(9, `CSR_ADDR_SIE, `CSR_MASK_SIE, 2);          // alias of mie
        set_entry(10, `CSR_ADDR_STVEC, `CSR_MASK_STVEC, 8);
        set_entry(11, `CSR_ADDR_SSCRATCH, `CSR_MASK_SSCRATCH, 9);
        set_entry(12, `CSR_ADDR_SEPC, `CSR_MASK_SEPC, 10);
        set_entry(13, `CSR_ADDR_SCAUSE, `CSR_MASK_SCAUSE, 11);
        set_entry(14, `CSR_ADDR_STVAL, `CSR_MASK_STVAL, 12);
        set_entry(15, `CSR_ADDR_SATP, `CSR_MASK_SATP, 13);
        set_entry(16, 12'h7C0, '0, 14);                         // unknown address

        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < n_entries; i++) begin
            check_outputs();
            drive_inputs(0, i);
            @(negedge clk);
        end
        for (int i = 0; i < write_cycles; i++) begin
            check_outputs();
            drive_inputs(1, 0);
            @(negedge clk);
        end
        for (int i = 0; i < mixed_cycles; i++) begin
            check_outputs();
            drive_inputs(2, 0);
            @(negedge clk);
        end
        check_outputs();

        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+.
csr_pkg.sv
csr_trap_ctrl.sv
csr_regs.sv
csr_read_mux.sv
csr_redirect.sv
csr_file.sv
tb_clock_gen.sv
tb_csr_file.sv

/* Bender.yml */
package:
  name: csr_file

sources:
  - include_dirs:
      - .
    files:
      - csr_pkg.sv
      - csr_trap_ctrl.sv
      - csr_regs.sv
      - csr_read_mux.sv
      - csr_redirect.sv
      - csr_file.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock_gen.sv
      - tb_csr_file.sv
